//--- common/nice_config.svh
/*
 nice coprocessor build configuration
 widths, ldbuf batch size, parameter RAM depth and memory window
*/
`ifndef NICE_CONFIG_SVH
`define NICE_CONFIG_SVH

// register and bus data width
`define NICE_XLEN 32

// system memory address width
`define NICE_ADDR_W 32

// words copied by one ldbuf
`define NICE_LDBUF_BATCH 16

// parameter RAM address width, 1024 words
`define NICE_PRAM_AW 10

// window where the weight images live in system memory
`define NICE_MEM_OFFSET 32'h9000_4000

// byte step between consecutive word reads
`define NICE_WORD_STRIDE 4

`endif

//--- common/nice_isa_pkg.sv
/*
 nice instruction set definitions
 custom-3 encodings, operation codes and CPU request/response payloads
*/
`include "nice_config.svh"

package nice_isa_pkg;

   // R-type field layout
   typedef struct packed {
      logic [6:0] func7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] func3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_rtype_t;

   localparam logic [6:0] OPC_CUSTOM3 = 7'h7b;

   // func3/func7 pairs
   localparam logic [2:0] F3_RDSTAT = 3'b110;
   localparam logic [6:0] F7_RDSTAT = 7'b0000001;
   localparam logic [2:0] F3_START  = 3'b111;
   localparam logic [6:0] F7_START  = 7'b0000010;
   localparam logic [2:0] F3_LDBUF  = 3'b110;
   localparam logic [6:0] F7_LDBUF  = 7'b0000100;

   // rdstat status word layout
   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_VALID_BIT = 1;

   // decoded operation, doubles as the controller state
   typedef enum logic [2:0] {IDLE, RDSTAT, START, LDBUF, ILLEGAL} nice_op_e;

   // ldbuf sequencer states
   typedef enum logic [1:0] {LD_IDLE, LD_ANS, LD_LOAD} ldbuf_state_e;

   typedef struct packed {
      logic [`NICE_XLEN-1:0] inst;
      logic [`NICE_XLEN-1:0] rs1;
      logic [`NICE_XLEN-1:0] rs2;
   } nice_req_t;

   typedef struct packed {
      logic [`NICE_XLEN-1:0] rdat;
      logic                  err;
   } nice_rsp_t;

endpackage

//--- common/nice_bus_pkg.sv
/*
 nice memory-side definitions
 ICB command/response, parameter RAM write and classifier interface types
*/
`include "nice_config.svh"

package nice_bus_pkg;

   ////////////////////////////////////////
   // ICB
   ////////////////////////////////////////
   typedef struct packed {
      logic [`NICE_ADDR_W-1:0] addr;
      logic                    read;
      logic [`NICE_XLEN-1:0]   wdata;
      logic [1:0]              size;
   } icb_cmd_t;

   typedef struct packed {
      logic [`NICE_XLEN-1:0] rdata;
      logic                  err;
   } icb_rsp_t;

   // word transfers only
   localparam logic [1:0] ICB_SIZE_WORD = 2'b10;

   ////////////////////////////////////////
   // parameter RAM and classifier
   ////////////////////////////////////////
   typedef struct packed {
      logic                     en;
      logic [`NICE_PRAM_AW-1:0] addr;
      logic [`NICE_XLEN-1:0]    data;
   } pram_wr_t;

   // weight is the low half of a RAM word
   typedef logic [15:0] weight_t;

   typedef logic [4:0] accel_class_t;

   typedef struct packed {
      logic         valid;
      accel_class_t cls;
   } accel_result_t;

endpackage

//--- verilog/nice_ctrl.sv
/*
 nice command controller
 decodes custom-3 instructions, sequences each command, builds the response
*/
`include "nice_config.svh"

module nice_ctrl (
   input  logic                        nice_clk,
   input  logic                        nice_rst_n,
   input  logic                        req_valid_i,
   input  nice_isa_pkg::nice_req_t     req_i,
   output logic                        req_ready_o,
   output logic                        rsp_valid_o,
   output nice_isa_pkg::nice_rsp_t     rsp_o,
   input  logic                        rsp_ready_i,
   input  logic                        busy_i,
   input  logic                        run_i,
   input  logic                        result_valid_i,
   input  logic [`NICE_XLEN-1:0]       result_i,
   input  logic                        ldbuf_done_i,
   input  logic                        ldbuf_err_i,
   output logic                        ldbuf_go_o,
   output logic [`NICE_XLEN-1:0]       ldbuf_rs1_o,
   output logic [`NICE_XLEN-1:0]       ldbuf_rs2_o,
   output logic                        run_req_o,
   output nice_isa_pkg::nice_op_e      op_o,
   output logic                        active_o
);

   nice_isa_pkg::rv_rtype_t inst;
   nice_isa_pkg::nice_op_e  dec_op;
   nice_isa_pkg::nice_op_e  state_q;
   logic                    launch_q;
   logic                    done_q;
   logic                    req_hs;
   logic                    rsp_hs;
   logic [`NICE_XLEN-1:0]   rs1_q;
   logic [`NICE_XLEN-1:0]   rs2_q;
   logic [`NICE_XLEN-1:0]   stat_word;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////
   assign inst = req_i.inst;

   always_comb begin
      dec_op = nice_isa_pkg::ILLEGAL;
      if (inst.opcode == nice_isa_pkg::OPC_CUSTOM3) begin
         if (inst.func3 == nice_isa_pkg::F3_RDSTAT && inst.func7 == nice_isa_pkg::F7_RDSTAT) begin
            dec_op = nice_isa_pkg::RDSTAT;
         end else if (inst.func3 == nice_isa_pkg::F3_START &&
                      inst.func7 == nice_isa_pkg::F7_START) begin
            dec_op = nice_isa_pkg::START;
         end else if (inst.func3 == nice_isa_pkg::F3_LDBUF &&
                      inst.func7 == nice_isa_pkg::F7_LDBUF) begin
            dec_op = nice_isa_pkg::LDBUF;
         end
      end
   end

   assign req_ready_o = (state_q == nice_isa_pkg::IDLE);
   assign req_hs      = req_valid_i & req_ready_o;
   assign rsp_hs      = rsp_valid_o & rsp_ready_i;
   assign active_o    = (state_q == nice_isa_pkg::IDLE) ? req_valid_i : 1'b1;

   // status block sees the operation only on its accept cycle
   assign op_o = req_hs ? dec_op : nice_isa_pkg::IDLE;

   // operands, held for the whole command
   always_ff @(posedge nice_clk) begin
      if (req_hs) begin
         rs1_q <= req_i.rs1;
         rs2_q <= req_i.rs2;
      end
   end

   assign ldbuf_rs1_o = rs1_q;
   assign ldbuf_rs2_o = rs2_q;

   // start waits for an idle classifier, ldbuf for a stopped run
   assign run_req_o  = (state_q == nice_isa_pkg::START) & ~launch_q;
   assign ldbuf_go_o = (state_q == nice_isa_pkg::LDBUF) & ~launch_q & ~run_i;

   ////////////////////////////////////////
   // command FSM
   ////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         state_q  <= nice_isa_pkg::IDLE;
         launch_q <= 1'b0;
         done_q   <= 1'b0;
      end else if (state_q == nice_isa_pkg::IDLE) begin
         if (req_hs) begin
            state_q <= dec_op;
         end
      end else if (rsp_hs) begin
         state_q  <= nice_isa_pkg::IDLE;
         launch_q <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         // same grant the status block uses to set run
         if ((run_req_o & ~busy_i) | ldbuf_go_o) begin
            launch_q <= 1'b1;
         end
         if (state_q == nice_isa_pkg::LDBUF && ldbuf_done_i) begin
            done_q <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // response
   ////////////////////////////////////////
   always_comb begin
      stat_word = '0;
      stat_word[nice_isa_pkg::STAT_BUSY_BIT]  = busy_i;
      stat_word[nice_isa_pkg::STAT_VALID_BIT] = result_valid_i;
   end

   always_comb begin
      rsp_valid_o = 1'b0;
      rsp_o       = '0;
      case (state_q)
         nice_isa_pkg::RDSTAT: begin
            rsp_valid_o = 1'b1;
            if (rs1_q == `NICE_XLEN'd0) begin
               rsp_o.rdat = stat_word;
            end else if (rs1_q == `NICE_XLEN'd1) begin
               rsp_o.rdat = result_i;
            end
         end
         nice_isa_pkg::START: begin
            rsp_valid_o = launch_q;
            rsp_o.rdat  = `NICE_XLEN'd1;
         end
         nice_isa_pkg::LDBUF: begin
            rsp_valid_o = done_q;
            rsp_o.rdat  = `NICE_XLEN'd1;
            rsp_o.err   = ldbuf_err_i;
         end
         nice_isa_pkg::ILLEGAL: begin
            rsp_valid_o = 1'b1;
            rsp_o.err   = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

//--- verilog/nice_status_regs.sv
/*
 nice status registers
 run, busy and result flags, class latch and classifier start/reset control
*/
`include "nice_config.svh"

module nice_status_regs (
   input  logic                        nice_clk,
   input  logic                        nice_rst_n,
   input  nice_isa_pkg::nice_op_e      op_i,
   input  logic                        run_req_i,
   input  logic                        ldbuf_done_i,
   input  nice_bus_pkg::accel_result_t accel_result_i,
   output logic                        busy_o,
   output logic                        run_o,
   output logic                        result_valid_o,
   output logic [`NICE_XLEN-1:0]       result_o,
   output logic                        accel_start_o,
   output logic                        accel_rst_n_o,
   output nice_bus_pkg::accel_result_t result_class_o
);

   logic                       run_q;
   logic                       run_prev_q;
   logic                       load_q;
   logic                       rvalid_q;
   logic                       rst_rel_q;
   nice_bus_pkg::accel_class_t class_q;

   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         run_q      <= 1'b0;
         run_prev_q <= 1'b0;
         load_q     <= 1'b0;
         rvalid_q   <= 1'b0;
         rst_rel_q  <= 1'b0;
      end else begin
         // classifier result ends the run
         if (accel_result_i.valid) begin
            run_q <= 1'b0;
         end else if (run_req_i & ~busy_o) begin
            run_q <= 1'b1;
         end
         run_prev_q <= run_q;
         if (op_i == nice_isa_pkg::LDBUF) begin
            load_q <= 1'b1;
         end else if (ldbuf_done_i) begin
            load_q <= 1'b0;
         end
         if (accel_result_i.valid) begin
            rvalid_q <= 1'b1;
         end else if (op_i == nice_isa_pkg::START || op_i == nice_isa_pkg::LDBUF) begin
            rvalid_q <= 1'b0;
         end
         // released once, never asserted again
         if (ldbuf_done_i) begin
            rst_rel_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge nice_clk) begin
      if (accel_result_i.valid) begin
         class_q <= accel_result_i.cls;
      end
   end

   assign busy_o         = run_q | load_q;
   assign run_o          = run_q;
   assign result_valid_o = rvalid_q;
   assign result_o       = `NICE_XLEN'(class_q);
   // one pulse per rising edge of run
   assign accel_start_o  = run_q & ~run_prev_q;
   assign accel_rst_n_o  = rst_rel_q;

   assign result_class_o.valid = rvalid_q;
   assign result_class_o.cls   = class_q;

endmodule

//--- ldbuf/nice_ldbuf_dma.sv
/*
 ldbuf DMA
 reads a fixed batch of words over ICB and writes them into the parameter RAM
*/
`include "nice_config.svh"

module nice_ldbuf_dma (
   input  logic                     nice_clk,
   input  logic                     nice_rst_n,
   input  logic                     go_i,
   input  logic [`NICE_XLEN-1:0]    rs1_i,
   input  logic [`NICE_XLEN-1:0]    rs2_i,
   output logic                     icb_cmd_valid_o,
   output nice_bus_pkg::icb_cmd_t   icb_cmd_o,
   input  logic                     icb_cmd_ready_i,
   input  logic                     icb_rsp_valid_i,
   input  nice_bus_pkg::icb_rsp_t   icb_rsp_i,
   output logic                     icb_rsp_ready_o,
   output nice_bus_pkg::pram_wr_t   pram_wr_o,
   output logic                     done_o,
   output logic                     err_o,
   output logic                     holdup_o,
   output logic                     loading_o
);

   localparam int CNT_W = $clog2(`NICE_LDBUF_BATCH) + 1;

   nice_isa_pkg::ldbuf_state_e state_q;
   logic                       cmd_valid_q;
   logic                       err_q;
   logic [CNT_W-1:0]           idx_q;
   logic [`NICE_ADDR_W-1:0]    addr_q;
   logic [`NICE_PRAM_AW-1:0]   base_q;
   logic [`NICE_XLEN-1:0]      buf_q;
   logic                       start;
   logic                       last;
   logic                       cmd_hs;
   logic                       rsp_hs;

   assign start  = (state_q == nice_isa_pkg::LD_IDLE) & go_i;
   assign last   = (idx_q == CNT_W'(`NICE_LDBUF_BATCH - 1));
   assign cmd_hs = icb_cmd_valid_o & icb_cmd_ready_i;
   // one read outstanding, so any response in ANS is ours
   assign rsp_hs = (state_q == nice_isa_pkg::LD_ANS) & icb_rsp_valid_i & icb_rsp_ready_o;

   ////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (!nice_rst_n) begin
         state_q     <= nice_isa_pkg::LD_IDLE;
         cmd_valid_q <= 1'b0;
         err_q       <= 1'b0;
         idx_q       <= '0;
      end else begin
         case (state_q)
            nice_isa_pkg::LD_IDLE: begin
               if (go_i) begin
                  state_q     <= nice_isa_pkg::LD_ANS;
                  cmd_valid_q <= 1'b1;
                  err_q       <= 1'b0;
                  idx_q       <= '0;
               end
            end
            nice_isa_pkg::LD_ANS: begin
               if (cmd_hs) begin
                  cmd_valid_q <= 1'b0;
               end
               if (rsp_hs) begin
                  state_q <= nice_isa_pkg::LD_LOAD;
                  if (icb_rsp_i.err) begin
                     err_q <= 1'b1;
                  end
               end
            end
            nice_isa_pkg::LD_LOAD: begin
               // word goes into the RAM this cycle
               if (last) begin
                  state_q <= nice_isa_pkg::LD_IDLE;
               end else begin
                  state_q     <= nice_isa_pkg::LD_ANS;
                  cmd_valid_q <= 1'b1;
                  idx_q       <= idx_q + CNT_W'(1);
               end
            end
            default: begin
               state_q <= nice_isa_pkg::LD_IDLE;
            end
         endcase
      end
   end

   // read address, RAM base and returned word
   always_ff @(posedge nice_clk) begin
      if (start) begin
         addr_q <= rs1_i + `NICE_MEM_OFFSET;
         base_q <= rs2_i[8 +: `NICE_PRAM_AW];
      end else if (state_q == nice_isa_pkg::LD_LOAD) begin
         addr_q <= addr_q + `NICE_ADDR_W'(`NICE_WORD_STRIDE);
      end
      if (rsp_hs) begin
         buf_q <= icb_rsp_i.rdata;
      end
   end

   ////////////////////////////////////////
   // outputs
   ////////////////////////////////////////
   assign icb_cmd_valid_o = cmd_valid_q;
   assign icb_cmd_o.addr  = addr_q;
   assign icb_cmd_o.read  = 1'b1;
   assign icb_cmd_o.wdata = '0;
   assign icb_cmd_o.size  = nice_bus_pkg::ICB_SIZE_WORD;
   assign icb_rsp_ready_o = 1'b1;

   assign pram_wr_o.en   = (state_q == nice_isa_pkg::LD_LOAD);
   assign pram_wr_o.addr = base_q + `NICE_PRAM_AW'(idx_q);
   assign pram_wr_o.data = buf_q;

   assign done_o    = (state_q == nice_isa_pkg::LD_LOAD) & last;
   assign err_o     = err_q;
   assign holdup_o  = (state_q != nice_isa_pkg::LD_IDLE);
   assign loading_o = holdup_o | go_i;

endmodule

//--- verilog/nice_param_ram.sv
/*
 parameter RAM, single port
 filled by the ldbuf DMA, then read by the classifier for weights
*/
`include "nice_config.svh"

module nice_param_ram (
   input  logic                     nice_clk,
   input  nice_bus_pkg::pram_wr_t   wr_i,
   input  logic                     accel_rst_n_i,
   input  logic [`NICE_PRAM_AW-1:0] accel_waddr_i,
   output nice_bus_pkg::weight_t    weight_o
);

   logic [`NICE_XLEN-1:0]    mem [2**`NICE_PRAM_AW];
   logic [`NICE_XLEN-1:0]    rd_q;
   logic [`NICE_PRAM_AW-1:0] addr;

   // DMA owns the port until the classifier leaves reset
   assign addr = accel_rst_n_i ? accel_waddr_i : wr_i.addr;

   always_ff @(posedge nice_clk) begin
      if (wr_i.en) begin
         mem[addr] <= wr_i.data;
      end
      rd_q <= mem[addr];
   end

   assign weight_o = rd_q[15:0];

endmodule

//--- verilog/nice_core_top.sv
/*
 nice coprocessor core, command side of the classifier
 ties the controller, status block, ldbuf DMA and parameter RAM together
*/
`include "nice_config.svh"

module nice_core_top (
   input  logic                             nice_clk,
   input  logic                             nice_rst_n,
   // cpu request
   input  logic                             req_valid_i,
   input  nice_isa_pkg::nice_req_t          req_i,
   output logic                             req_ready_o,
   // cpu response
   output logic                             rsp_valid_o,
   output nice_isa_pkg::nice_rsp_t          rsp_o,
   input  logic                             rsp_ready_i,
   // memory bus
   output logic                             icb_cmd_valid_o,
   output nice_bus_pkg::icb_cmd_t           icb_cmd_o,
   input  logic                             icb_cmd_ready_i,
   input  logic                             icb_rsp_valid_i,
   input  nice_bus_pkg::icb_rsp_t           icb_rsp_i,
   output logic                             icb_rsp_ready_o,
   // classifier
   output logic                             accel_start_o,
   output logic                             accel_rst_n_o,
   input  logic [`NICE_PRAM_AW-1:0]         accel_waddr_i,
   output nice_bus_pkg::weight_t            accel_weight_o,
   input  nice_bus_pkg::accel_result_t      accel_result_i,
   output nice_bus_pkg::accel_result_t      result_o,
   // system
   output logic                             active_o,
   output logic                             mem_holdup_o
);

   logic                   busy;
   logic                   run;
   logic                   result_valid;
   logic [`NICE_XLEN-1:0]  result_word;
   logic                   ldbuf_go;
   logic                   ldbuf_done;
   logic                   ldbuf_err;
   logic [`NICE_XLEN-1:0]  ldbuf_rs1;
   logic [`NICE_XLEN-1:0]  ldbuf_rs2;
   logic                   run_req;
   nice_isa_pkg::nice_op_e op;
   logic                   ctrl_active;
   logic                   dma_loading;
   nice_bus_pkg::pram_wr_t pram_wr;

   // core stays active while a transfer runs
   assign active_o = ctrl_active | dma_loading;

   nice_ctrl u_ctrl (
      .nice_clk       (nice_clk),
      .nice_rst_n     (nice_rst_n),
      .req_valid_i    (req_valid_i),
      .req_i          (req_i),
      .req_ready_o    (req_ready_o),
      .rsp_valid_o    (rsp_valid_o),
      .rsp_o          (rsp_o),
      .rsp_ready_i    (rsp_ready_i),
      .busy_i         (busy),
      .run_i          (run),
      .result_valid_i (result_valid),
      .result_i       (result_word),
      .ldbuf_done_i   (ldbuf_done),
      .ldbuf_err_i    (ldbuf_err),
      .ldbuf_go_o     (ldbuf_go),
      .ldbuf_rs1_o    (ldbuf_rs1),
      .ldbuf_rs2_o    (ldbuf_rs2),
      .run_req_o      (run_req),
      .op_o           (op),
      .active_o       (ctrl_active)
   );

   nice_status_regs u_status (
      .nice_clk       (nice_clk),
      .nice_rst_n     (nice_rst_n),
      .op_i           (op),
      .run_req_i      (run_req),
      .ldbuf_done_i   (ldbuf_done),
      .accel_result_i (accel_result_i),
      .busy_o         (busy),
      .run_o          (run),
      .result_valid_o (result_valid),
      .result_o       (result_word),
      .accel_start_o  (accel_start_o),
      .accel_rst_n_o  (accel_rst_n_o),
      .result_class_o (result_o)
   );

   nice_ldbuf_dma u_dma (
      .nice_clk        (nice_clk),
      .nice_rst_n      (nice_rst_n),
      .go_i            (ldbuf_go),
      .rs1_i           (ldbuf_rs1),
      .rs2_i           (ldbuf_rs2),
      .icb_cmd_valid_o (icb_cmd_valid_o),
      .icb_cmd_o       (icb_cmd_o),
      .icb_cmd_ready_i (icb_cmd_ready_i),
      .icb_rsp_valid_i (icb_rsp_valid_i),
      .icb_rsp_i       (icb_rsp_i),
      .icb_rsp_ready_o (icb_rsp_ready_o),
      .pram_wr_o       (pram_wr),
      .done_o          (ldbuf_done),
      .err_o           (ldbuf_err),
      .holdup_o        (mem_holdup_o),
      .loading_o       (dma_loading)
   );

   nice_param_ram u_pram (
      .nice_clk      (nice_clk),
      .wr_i          (pram_wr),
      .accel_rst_n_i (accel_rst_n_o),
      .accel_waddr_i (accel_waddr_i),
      .weight_o      (accel_weight_o)
   );

endmodule

//--- verif/nice_tb_clk.sv
/*
 testbench clock and reset
 4 ns clock, reset held low for 10 cycles
*/
module nice_tb_clk (
   output logic nice_clk,
   output logic nice_rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      nice_clk = 1'b0;
      forever #2 nice_clk = ~nice_clk;
   end

   // release on a falling edge, like the other inputs
   initial begin
      nice_rst_n = 1'b0;
      repeat (10) @(posedge nice_clk);
      @(negedge nice_clk);
      nice_rst_n = 1'b1;
   end

endmodule

//--- verif/nice_core_tb.sv
/*
 nice core testbench
 pattern-driven commands, ICB memory model, classifier model and checks
*/
`include "nice_config.svh"

module nice_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // command codes in the pattern file
   localparam int OP_RDSTAT = 0;
   localparam int OP_START  = 1;
   localparam int OP_LDBUF  = 2;
   localparam int OP_ILLEGAL = 3;
   localparam int OP_WAIT   = 4;

   logic nice_clk;
   logic nice_rst_n;
   logic req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
   nice_isa_pkg::nice_req_t req_i;
   nice_isa_pkg::nice_rsp_t rsp_o;
   logic icb_cmd_valid_o, icb_cmd_ready_i, icb_rsp_valid_i, icb_rsp_ready_o;
   nice_bus_pkg::icb_cmd_t icb_cmd_o;
   nice_bus_pkg::icb_rsp_t icb_rsp_i;
   logic accel_start_o, accel_rst_n_o, active_o, mem_holdup_o;
   logic [`NICE_PRAM_AW-1:0] accel_waddr_i;
   nice_bus_pkg::weight_t accel_weight_o;
   nice_bus_pkg::accel_result_t accel_result_i, result_o;

   logic [31:0] pat [0:255];
   logic [31:0] lfsr_q = 32'h82de_4406;
   int n_cmds, img_base, val_errs, other_errs, read_count, start_count;
   int cycles, limit;
   logic [31:0] ld_rs1;
   int ld_first;
   logic [4:0] cur_class;
   bit sim_done;

   nice_tb_clk u_clk (.nice_clk(nice_clk), .nice_rst_n(nice_rst_n));

   nice_core_top u_dut (.*);

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   // taps 32 22 2 1
   function logic lfsr_step();
      logic nb;
      nb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], nb};
      return nb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   // R-type word built from the custom-3 encodings
   function automatic logic [31:0] build_inst(input int op);
      logic [6:0] f7;
      logic [2:0] f3;
      f3 = 3'b110;
      f7 = 7'b0000001;
      if (op == OP_START) begin
         f3 = 3'b111;
         f7 = 7'b0000010;
      end else if (op == OP_LDBUF) begin
         f7 = 7'b0000100;
      end else if (op == OP_ILLEGAL) begin
         f7 = 7'b1111111;
      end
      return {f7, 5'd0, 5'd0, f3, 5'd0, 7'h7b};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         val_errs++;
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_cond(input bit ok, input string what);
      assert (ok) else begin
         other_errs++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   // one request, then wait for its response under random back-pressure
   task automatic run_cmd(input int op, input logic [31:0] rs1, input logic [31:0] rs2,
                          input logic [31:0] exp_rdat, input logic exp_err);
      bit rdy;
      bit hs;
      bit held;
      nice_isa_pkg::nice_rsp_t got;
      @(negedge nice_clk);
      req_valid_i = 1'b1;
      req_i = '{inst: build_inst(op), rs1: rs1, rs2: rs2};
      forever begin
         rdy = req_ready_o;
         @(posedge nice_clk);
         if (rdy) break;
         @(negedge nice_clk);
      end
      hs = 1'b0;
      held = 1'b0;
      while (!hs) begin
         @(negedge nice_clk);
         req_valid_i = 1'b0;
         // a stalled response stays up until taken
         if (held) begin
            check_cond(rsp_valid_o === 1'b1, "response dropped before it was accepted");
         end
         check_val("active_o", 32'(active_o), 32'd1);
         rsp_ready_i = lfsr_step();
         got = rsp_o;
         hs = rsp_valid_o & rsp_ready_i;
         held = rsp_valid_o & ~rsp_ready_i;
         @(posedge nice_clk);
      end
      @(negedge nice_clk);
      rsp_ready_i = 1'b0;
      check_val("active_o", 32'(active_o), 32'd0);
      check_val("rsp_o.rdat", got.rdat, exp_rdat);
      check_val("rsp_o.err", 32'(got.err), 32'(exp_err));
   endtask

   ////////////////////////////////////////
   // ICB memory model
   ////////////////////////////////////////
   initial begin
      logic stall;
      logic [31:0] stall_addr;
      int dly;
      int k;
      icb_cmd_ready_i = 1'b0;
      icb_rsp_valid_i = 1'b0;
      icb_rsp_i = '0;
      stall = 1'b0;
      stall_addr = '0;
      forever begin
         @(negedge nice_clk);
         if (stall) begin
            check_cond(icb_cmd_valid_o === 1'b1, "ICB command dropped while stalled");
            check_val("icb_cmd_o.addr", icb_cmd_o.addr, stall_addr);
         end
         icb_cmd_ready_i = lfsr_step();
         stall = icb_cmd_valid_o & ~icb_cmd_ready_i;
         stall_addr = icb_cmd_o.addr;
         if (icb_cmd_valid_o && icb_cmd_ready_i) begin
            k = read_count - ld_first;
            check_val("icb_cmd_o.addr", icb_cmd_o.addr,
                      `NICE_MEM_OFFSET + ld_rs1 + 32'(4 * k));
            check_val("icb_cmd_o.read", 32'(icb_cmd_o.read), 32'd1);
            check_val("icb_cmd_o.size", 32'(icb_cmd_o.size), 32'd2);
            check_val("icb_cmd_o.wdata", icb_cmd_o.wdata, 32'd0);
            check_val("mem_holdup_o", 32'(mem_holdup_o), 32'd1);
            read_count++;
            @(posedge nice_clk);
            dly = rand_bits(2);
            repeat (dly) @(negedge nice_clk);
            @(negedge nice_clk);
            icb_rsp_valid_i = 1'b1;
            icb_rsp_i = '{rdata: pat[img_base + k], err: 1'b0};
            check_val("icb_rsp_ready_o", 32'(icb_rsp_ready_o), 32'd1);
            @(negedge nice_clk);
            icb_rsp_valid_i = 1'b0;
            stall = 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // classifier model
   ////////////////////////////////////////
   initial begin
      int dly;
      accel_result_i = '0;
      forever begin
         @(negedge nice_clk);
         if (accel_start_o) begin
            dly = 20 + rand_bits(4);
            repeat (dly) @(negedge nice_clk);
            accel_result_i = '{valid: 1'b1, cls: cur_class};
            @(negedge nice_clk);
            accel_result_i = '0;
         end
      end
   end

   // every cycle of accel_start_o counts, also while the model waits
   initial begin
      forever begin
         @(negedge nice_clk);
         if (accel_start_o === 1'b1) begin
            start_count++;
         end
      end
   end

   // cycle limit from command count, batch and worst stall
   initial begin
      cycles = 0;
      @(posedge nice_rst_n);
      limit = n_cmds * (`NICE_LDBUF_BATCH * 16 + 80) + 200;
      while (!sim_done && cycles < limit) begin
         @(posedge nice_clk);
         cycles++;
      end
      if (!sim_done) begin
         $display("timeout: run stalled after %0d cycles", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // command sequence
   ////////////////////////////////////////
   initial begin
      int op;
      int starts;
      logic [31:0] rs1, rs2;
      logic [`NICE_PRAM_AW-1:0] base;
      req_valid_i = 1'b0;
      req_i = '0;
      rsp_ready_i = 1'b0;
      accel_waddr_i = '0;
      starts = 0;
      $readmemh("verif/nice_patterns.txt", pat);
      n_cmds = pat[0];
      img_base = 1 + 5 * n_cmds;
      @(posedge nice_rst_n);
      @(negedge nice_clk);
      check_val("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
      check_val("icb_cmd_valid_o", 32'(icb_cmd_valid_o), 32'd0);
      check_val("accel_start_o", 32'(accel_start_o), 32'd0);
      check_val("accel_rst_n_o", 32'(accel_rst_n_o), 32'd0);
      check_val("mem_holdup_o", 32'(mem_holdup_o), 32'd0);
      check_val("req_ready_o", 32'(req_ready_o), 32'd1);
      check_val("active_o", 32'(active_o), 32'd0);
      check_val("icb_rsp_ready_o", 32'(icb_rsp_ready_o), 32'd1);
      for (int c = 0; c < n_cmds; c++) begin
         op = pat[1 + 5 * c];
         rs1 = pat[2 + 5 * c];
         rs2 = pat[3 + 5 * c];
         if (op == OP_WAIT) begin
            while (result_o.valid !== 1'b1) @(negedge nice_clk);
            check_val("result_o.cls", 32'(result_o.cls), 32'(cur_class));
            check_val("accel_start_o pulses", start_count, starts);
         end else begin
            if (op == OP_LDBUF) begin
               ld_rs1 = rs1;
               ld_first = read_count;
            end
            if (op == OP_START) begin
               cur_class = rs2[4:0];
               starts++;
            end
            run_cmd(op, rs1, rs2, pat[4 + 5 * c], pat[5 + 5 * c][0]);
         end
         if (op == OP_LDBUF) begin
            check_cond(read_count - ld_first == `NICE_LDBUF_BATCH, "wrong ldbuf read count");
            check_val("accel_rst_n_o", 32'(accel_rst_n_o), 32'd1);
            check_val("mem_holdup_o", 32'(mem_holdup_o), 32'd0);
            base = rs2[8 +: `NICE_PRAM_AW];
            // weight readback through the classifier port
            for (int k = 0; k < `NICE_LDBUF_BATCH; k++) begin
               accel_waddr_i = base + `NICE_PRAM_AW'(k);
               @(negedge nice_clk);
               check_val("accel_weight_o", 32'(accel_weight_o), 32'(pat[img_base + k][15:0]));
            end
         end
      end
      sim_done = 1'b1;
      $display("value errors %0d, other errors %0d", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+common
common/nice_isa_pkg.sv
common/nice_bus_pkg.sv
verilog/nice_ctrl.sv
verilog/nice_status_regs.sv
ldbuf/nice_ldbuf_dma.sv
verilog/nice_param_ram.sv
verilog/nice_core_top.sv
verif/nice_tb_clk.sv
verif/nice_core_tb.sv

//--- Makefile
# Verilator build and run of the nice core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module nice_core_tb -o nice_sim
	./obj_dir/nice_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/nice_patterns.txt
// word 0 command count, then per command: op rs1 rs2 exp_rdat exp_err
// op 0 rdstat, 1 start (rs2 = class), 2 ldbuf, 3 illegal, 4 wait result; then 16 image words
0000000c
00000002 00000100 00002000 00000001 00000000
00000000 00000000 00000000 00000000 00000000
00000001 00000000 0000000b 00000001 00000000
00000000 00000000 00000000 00000001 00000000
00000004 00000000 00000000 00000000 00000000
00000000 00000001 00000000 0000000b 00000000
00000000 00000000 00000000 00000002 00000000
00000003 00000000 00000000 00000000 00000001
00000000 00000005 00000000 00000000 00000000
00000001 00000000 00000015 00000001 00000000
00000004 00000000 00000000 00000000 00000000
00000000 00000001 00000000 00000015 00000000
// memory image
a5a51234
0bad5678
1111beef
2222cafe
33330001
4444fffe
55558000
66667fff
7777abcd
8888dcba
99990f0f
aaaaf0f0
bbbb1357
cccc2468
dddd9999
eeee4242
